/* Bender.yml */
package:
  name: packet_tx

sources:
  - include_dirs:
      - source
    files:
      - source/mem_pkg.sv
      - source/rmii_pkg.sv
      - source/packet_buffer_ram.sv
      - source/stream_from_memory.sv
      - source/bytes_to_dibits.sv
      - source/packet_tx_top.sv
      - target: test
        files:
          - sim/packet_tx_tb.sv

/* list.f */
+incdir+source
source/mem_pkg.sv
source/rmii_pkg.sv
source/packet_buffer_ram.sv
source/stream_from_memory.sv
source/bytes_to_dibits.sv
source/packet_tx_top.sv
sim/packet_tx_tb.sv

/* sim/packet_tx_tb.sv */
// streams byte ranges out of the packet buffer and rebuilds the bytes
// from the RMII dibits to compare them with a model of the buffer
`timescale 1ns/1ps
`include "stream_config.svh"

module packet_tx_tb;

	import mem_pkg::*;
	import rmii_pkg::*;

	typedef byte_t byte_queue_t[$];

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_SUBRANGES = 5;
	localparam int MAX_SUB_LEN = 64;
	localparam int BUSY_LEN = 40;
	localparam int REWRITE_LEN = 32;
	localparam int NUM_REWRITES = 4;
	localparam int ABORT_CYCLES = 30;
	localparam int FRESH_LEN = 48;
	localparam int SETTLE_CYCLES = 8;
	localparam int NUM_STREAMS = NUM_SUBRANGES + 5;
	localparam int STREAM_BYTES = `PACKET_BUFFER_SIZE + NUM_SUBRANGES * MAX_SUB_LEN +
		BUSY_LEN + REWRITE_LEN + FRESH_LEN;
	// load, resets, abort and settle time, plus four cycles per byte
	localparam int WATCHDOG_CYCLES = `PACKET_BUFFER_SIZE + 2 * RESET_CYCLES + ABORT_CYCLES +
		NUM_REWRITES + NUM_STREAMS * SETTLE_CYCLES + 4 * STREAM_BYTES + 200;

	logic clk;
	logic reset;
	logic write_enable;
	addr_t write_addr;
	byte_t write_val;
	logic start;
	bound_t read_start;
	bound_t read_end;
	logic busy;
	logic eth_txen;
	dibit_t eth_txd;

	byte_t model [`PACKET_BUFFER_SIZE];
	byte_queue_t expected;
	logic [31:0] lcg_state;

	// monitor counters that each stream clears
	int txen_cycles;
	int txen_runs;
	int busy_cycles;
	int busy_falls;
	int dibit_idx;
	byte_t shift_word;
	logic txen_prev;
	logic busy_prev;

	packet_tx_top DUT (
		.clk(clk),
		.reset(reset),
		.write_enable(write_enable),
		.write_addr(write_addr),
		.write_val(write_val),
		.start(start),
		.read_start(read_start),
		.read_end(read_end),
		.busy(busy),
		.eth_txen(eth_txen),
		.eth_txd(eth_txd)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int unsigned random_below(input int unsigned n);
		lcg_state = lcg_next(lcg_state);
		return lcg_state[31:8] % n;
	endfunction

	// bytes of [first, last) as the buffer should hold them
	function automatic byte_queue_t reference_bytes(input int first, input int last);
		byte_queue_t q;
		q = {};
		for (int a = first; a < last; a++) begin
			q.push_back(model[a]);
		end
		return q;
	endfunction

	task automatic report_error(input string msg);
		$display("Fail at %0t: %s", $time, msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_byte(input byte_t got, input byte_t exp, input string what);
		if (got !== exp) begin
			report_error($sformatf("%s: got %02h, expected %02h", what, got, exp));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			report_error($sformatf("%s: got %b, expected %b", what, got, exp));
		end
	endtask

	task automatic check_dibit(input dibit_t got, input dibit_t exp, input string what);
		if (got !== exp) begin
			report_error($sformatf("%s: got %b, expected %b", what, got, exp));
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
		end
	endtask

	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic write_byte(input int addr, input byte_t val);
		write_enable = 1'b1;
		write_addr = addr_t'(addr);
		write_val = val;
		model[addr] = val;
		step_cycle();
		write_enable = 1'b0;
	endtask

	task automatic load_buffer();
		for (int a = 0; a < `PACKET_BUFFER_SIZE; a++) begin
			lcg_state = lcg_next(lcg_state);
			write_byte(a, lcg_state[31:24]);
		end
	endtask

	task automatic pulse_start(input int first, input int last);
		start = 1'b1;
		read_start = bound_t'(first);
		read_end = bound_t'(last);
		step_cycle();
		start = 1'b0;
	endtask

	// poke_while_busy adds a second start that the DUT must ignore
	task automatic run_stream(input int first, input int last, input bit poke_while_busy);
		int len;
		len = last - first;
		expected = reference_bytes(first, last);
		txen_cycles = 0;
		txen_runs = 0;
		busy_cycles = 0;
		busy_falls = 0;
		pulse_start(first, last);
		check_flag(busy, 1'b1, "busy the cycle after start");
		if (poke_while_busy) begin
			repeat (3) step_cycle();
			pulse_start(0, `PACKET_BUFFER_SIZE);
		end
		while (busy) begin
			step_cycle();
		end
		check_flag(eth_txen, 1'b0, "txen once busy is low");
		// a stray second stream would raise busy again here
		repeat (SETTLE_CYCLES) begin
			step_cycle();
			check_flag(busy, 1'b0, "busy after the stream ended");
		end
		check_count(expected.size(), 0, "bytes never sent");
		check_count(txen_cycles, 4 * len, "txen cycles");
		check_count(txen_runs, (len == 0) ? 0 : 1, "separate txen runs");
		check_count(busy_falls, 1, "busy falling edges");
		if (len == 0) begin
			check_count(busy_cycles, 1, "busy cycles for an empty range");
		end
	endtask

	// sample the outputs mid-cycle
	always @(negedge clk) begin
		if (reset) begin
			dibit_idx = 0;
			txen_prev = 1'b0;
			busy_prev = 1'b0;
		end else begin
			if (eth_txen) begin
				if (!txen_prev) begin
					txen_runs++;
				end
				txen_cycles++;
				shift_word = {eth_txd, shift_word[7:2]};
				dibit_idx++;
				if (dibit_idx == 4) begin
					dibit_idx = 0;
					if (expected.size() == 0) begin
						report_error("a byte was sent past the end of the range");
					end else begin
						check_byte(shift_word, expected.pop_front(), "byte on the wire");
					end
				end
			end else begin
				check_dibit(eth_txd, 2'b00, "txd while txen is low");
			end
			if (busy) begin
				busy_cycles++;
			end
			if (busy_prev && !busy) begin
				busy_falls++;
			end
			txen_prev = eth_txen;
			busy_prev = busy;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the stream never completed within %0d cycles", WATCHDOG_CYCLES);
		$display("Test failed");
		$fatal(1);
	end

	initial begin : stimulus
		int first;
		int len;
		int addr;
		reset = 1'b1;
		start = 1'b0;
		read_start = '0;
		read_end = '0;
		write_enable = 1'b0;
		write_addr = '0;
		write_val = '0;
		lcg_state = 32'hab257170;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		load_buffer();

		run_stream(0, `PACKET_BUFFER_SIZE, 1'b0);

		for (int i = 0; i < NUM_SUBRANGES; i++) begin
			first = random_below(`PACKET_BUFFER_SIZE - MAX_SUB_LEN);
			len = 1 + random_below(MAX_SUB_LEN);
			run_stream(first, first + len, 1'b0);
		end

		run_stream(300, 300, 1'b0);
		run_stream(200, 200 + BUSY_LEN, 1'b1);

		// one byte in each slice of the range, always changed from its old value
		for (int i = 0; i < NUM_REWRITES; i++) begin
			addr = 500 + i * (REWRITE_LEN / NUM_REWRITES) +
				random_below(REWRITE_LEN / NUM_REWRITES);
			lcg_state = lcg_next(lcg_state);
			write_byte(addr, model[addr] ^ (lcg_state[23:16] | 8'h01));
		end
		run_stream(500, 500 + REWRITE_LEN, 1'b0);

		// reset lands while bytes are still on the wire
		expected = reference_bytes(100, 300);
		pulse_start(100, 300);
		repeat (ABORT_CYCLES) step_cycle();
		reset = 1'b1;
		step_cycle();
		check_flag(busy, 1'b0, "busy after reset");
		check_flag(eth_txen, 1'b0, "txen after reset");
		repeat (RESET_CYCLES - 1) step_cycle();
		reset = 1'b0;
		expected.delete();
		step_cycle();
		run_stream(700, 700 + FRESH_LEN, 1'b0);

		$display("Test completed successfully");
		$finish;
	end

endmodule

/* source/bytes_to_dibits.sv */
// serializes bytes into RMII dibits, least significant pair first
// a new byte is taken on the last dibit so bytes leave back to back
`timescale 1ns/1ps

module bytes_to_dibits (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input mem_pkg::byte_t in,
	output logic in_ready,
	output logic txen,
	output rmii_pkg::dibit_t txd
);

	import rmii_pkg::*;

	byte_dibits_t shift;

	// counts the dibits already sent of the current byte
	logic [1:0] dibit_cnt;
	logic last_dibit;
	logic load;

	assign last_dibit = txen && (dibit_cnt == 2'd3);
	assign in_ready = !txen || last_dibit;
	assign load = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			txen <= 1'b0;
			dibit_cnt <= 2'd0;
		end else if (load) begin
			txen <= 1'b1;
			dibit_cnt <= 2'd0;
		end else if (txen) begin
			dibit_cnt <= dibit_cnt + 2'd1;
			if (last_dibit) begin
				txen <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			shift.as_byte <= in;
		end else if (txen) begin
			shift.as_byte <= shift.as_byte >> 2;
		end
	end

	// the line stays quiet between frames
	assign txd = txen ? shift.dibits[0] : dibit_t'(2'b00);

endmodule

/* source/mem_pkg.sv */
// types for the packet buffer side of the transmit path
// ports use the scoped names, module bodies import the package
`include "stream_config.svh"

package mem_pkg;

	// one byte of packet data
	typedef logic [7:0] byte_t;

	// address of one byte in the buffer
	typedef logic [`PACKET_ADDR_WIDTH-1:0] addr_t;

	// start or exclusive end of a byte range, like in C
	typedef logic [`PACKET_LEN_WIDTH-1:0] bound_t;

endpackage

/* source/packet_buffer_ram.sv */
// single-clock packet buffer with a plain write port and a request/ready read port
// read data and read_ready show up one cycle after read_req
`timescale 1ns/1ps
`include "stream_config.svh"

module packet_buffer_ram (
	input logic clk,
	input logic reset,
	input logic write_enable,
	input mem_pkg::addr_t write_addr,
	input mem_pkg::byte_t write_val,
	input logic read_req,
	input mem_pkg::addr_t read_addr,
	output logic read_ready,
	output mem_pkg::byte_t read_out
);

	import mem_pkg::*;

	byte_t mem [`PACKET_BUFFER_SIZE];

	always_ff @(posedge clk) begin
		if (write_enable) begin
			mem[write_addr] <= write_val;
		end
	end

	// a read of an address being written this cycle gets the old byte
	always_ff @(posedge clk) begin
		if (read_req) begin
			read_out <= mem[read_addr];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			read_ready <= 1'b0;
		end else begin
			read_ready <= read_req;
		end
	end

endmodule

/* source/packet_tx_top.sv */
// Ethernet transmit path: packet buffer, range reader and RMII serializer
// load the buffer through the write port, then pulse start with a byte range
`timescale 1ns/1ps

module packet_tx_top (
	input logic clk,
	input logic reset,
	input logic write_enable,
	input mem_pkg::addr_t write_addr,
	input mem_pkg::byte_t write_val,
	input logic start,
	input mem_pkg::bound_t read_start,
	input mem_pkg::bound_t read_end,
	output logic busy,
	output logic eth_txen,
	output rmii_pkg::dibit_t eth_txd
);

	import mem_pkg::*;

	logic ram_read_req;
	addr_t ram_read_addr;
	logic ram_read_ready;
	byte_t ram_read_out;

	logic tx_valid;
	byte_t tx_byte;
	logic tx_ready;

	packet_buffer_ram ram_inst (
		.clk(clk),
		.reset(reset),
		.write_enable(write_enable),
		.write_addr(write_addr),
		.write_val(write_val),
		.read_req(ram_read_req),
		.read_addr(ram_read_addr),
		.read_ready(ram_read_ready),
		.read_out(ram_read_out)
	);

	stream_from_memory sfm_inst (
		.clk(clk),
		.reset(reset),
		.start(start),
		.read_start(read_start),
		.read_end(read_end),
		.ram_read_req(ram_read_req),
		.ram_read_addr(ram_read_addr),
		.ram_read_ready(ram_read_ready),
		.ram_read_out(ram_read_out),
		.out_valid(tx_valid),
		.out(tx_byte),
		.out_ready(tx_ready),
		.busy(busy)
	);

	bytes_to_dibits btd_inst (
		.clk(clk),
		.reset(reset),
		.in_valid(tx_valid),
		.in(tx_byte),
		.in_ready(tx_ready),
		.txen(eth_txen),
		.txd(eth_txd)
	);

endmodule

/* source/rmii_pkg.sv */
// types for the RMII side of the transmit path
// the shift word is loaded as a byte and read back as dibits
package rmii_pkg;

	import mem_pkg::*;

	// one RMII transmit symbol
	typedef logic [1:0] dibit_t;

	// dibits[0] is the least significant pair, sent first on the wire
	typedef union packed {
		byte_t as_byte;
		dibit_t [3:0] dibits;
	} byte_dibits_t;

endpackage

/* source/stream_config.svh */
// sizes of the packet buffer and its address fields
// include wherever the buffer depth or an address width is needed
`ifndef STREAM_CONFIG_SVH
`define STREAM_CONFIG_SVH

// bytes held by the packet buffer
`define PACKET_BUFFER_SIZE 1024

// bits needed to address one byte of the buffer
`define PACKET_ADDR_WIDTH 10

// one extra bit so an exclusive end can equal the buffer size
`define PACKET_LEN_WIDTH (`PACKET_ADDR_WIDTH + 1)

`endif

/* source/stream_from_memory.sv */
// reads the byte range [read_start, read_end) from the packet buffer
// and hands the bytes on over valid/ready, one byte waiting in a hold register
`timescale 1ns/1ps

module stream_from_memory (
	input logic clk,
	input logic reset,
	input logic start,
	input mem_pkg::bound_t read_start,
	input mem_pkg::bound_t read_end,
	output logic ram_read_req,
	output mem_pkg::addr_t ram_read_addr,
	input logic ram_read_ready,
	input mem_pkg::byte_t ram_read_out,
	output logic out_valid,
	output mem_pkg::byte_t out,
	input logic out_ready,
	output logic busy
);

	import mem_pkg::*;

	typedef enum logic [1:0] {
		state_idle,
		state_reading,
		state_holding,
		state_draining
	} state_t;

	state_t state;

	// next address to request, and the exclusive end of the range
	bound_t curr_addr;
	bound_t end_addr;
	bound_t next_addr;
	byte_t hold;

	assign next_addr = curr_addr + bound_t'(1);
	assign ram_read_addr = addr_t'(curr_addr);

	// a byte coming back from the RAM is offered in the same cycle
	assign out_valid = (state == state_holding) ||
		(state == state_reading && ram_read_ready);
	assign out = (state == state_holding) ? hold : ram_read_out;

	assign busy = (state != state_idle);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= state_idle;
			ram_read_req <= 1'b0;
		end else begin
			ram_read_req <= 1'b0;
			case (state)
				state_idle: begin
					if (start) begin
						if (read_start == read_end) begin
							state <= state_draining;
						end else begin
							state <= state_reading;
							ram_read_req <= 1'b1;
						end
					end
				end
				state_reading: begin
					if (ram_read_ready) begin
						if (!out_ready) begin
							state <= state_holding;
						end else if (next_addr == end_addr) begin
							state <= state_draining;
						end else begin
							// byte went straight through, fetch the next one
							ram_read_req <= 1'b1;
						end
					end
				end
				state_holding: begin
					if (out_ready) begin
						if (curr_addr == end_addr) begin
							state <= state_draining;
						end else begin
							state <= state_reading;
							ram_read_req <= 1'b1;
						end
					end
				end
				state_draining: begin
					// serializer ready with nothing offered means its last dibit is out
					if (out_ready) begin
						state <= state_idle;
					end
				end
				default: begin
					state <= state_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == state_idle && start) begin
			curr_addr <= read_start;
			end_addr <= read_end;
		end else if (state == state_reading && ram_read_ready) begin
			curr_addr <= next_addr;
		end
	end

	always_ff @(posedge clk) begin
		if (state == state_reading && ram_read_ready && !out_ready) begin
			hold <= ram_read_out;
		end
	end

endmodule
